/* intr_test.f */
logic/intr_test_pkg.sv
logic/csr_mgr.sv
logic/intr_cmd_engine.sv
logic/intr_rsp_tracker.sv
logic/intr_test_afu.sv
tb/host_chan_model.sv
tb/intr_test_tb.sv

/* logic/csr_mgr.sv */
// ==================================================
// MMIO lite slave with CSR read mux and start strobe
// ==================================================

`timescale 1ns/1ns

module csr_mgr
  #(
    parameter int NUM_INTR_IDS = 4
    )
   (
    input  logic                                      clk,
    input  logic                                      reset_n,

    // MMIO write path
    input  logic                                      mmio_wr_valid,
    input  intr_test_pkg::t_mmio_wr                   mmio_wr,
    output logic                                      mmio_wr_ready,
    output logic                                      mmio_b_valid,
    input  logic                                      mmio_b_ready,

    // MMIO read path
    input  logic                                      mmio_ar_valid,
    input  logic [intr_test_pkg::MMIO_ADDR_W-1:0]     mmio_ar_addr,
    output logic                                      mmio_ar_ready,
    output logic                                      mmio_r_valid,
    output intr_test_pkg::t_mmio_rd_rsp               mmio_r,
    input  logic                                      mmio_r_ready,

    // Status from the response tracker
    input  logic [$clog2(NUM_INTR_IDS):0]             intr_count,
    input  logic [NUM_INTR_IDS-1:0]                   intr_mask,
    input  logic                                      rsp_error,

    // Run control to engine and tracker
    output logic                                      start,
    output logic [$clog2(NUM_INTR_IDS)-1:0]           start_id
    );

    import intr_test_pkg::*;

    localparam int IDX_W = $clog2(NUM_INTR_IDS);
    localparam int CSR_IDX_W = $clog2(NUM_CSRS);

    // CSR index is the address above the 8-byte offset
    localparam int ADDR_IDX_W = MMIO_ADDR_W - 3;

    logic [ADDR_IDX_W-1:0] wr_idx;
    logic [ADDR_IDX_W-1:0] rd_idx;
    logic                  wr_fire;
    logic                  ar_fire;
    logic [63:0]           csr_rd [NUM_CSRS];
    logic [63:0]           rd_val;

    assign wr_idx = mmio_wr.addr[MMIO_ADDR_W-1:3];
    assign rd_idx = mmio_ar_addr[MMIO_ADDR_W-1:3];

    // ==================================================
    // Write path
    // ==================================================

    // One write in flight at a time
    assign mmio_wr_ready = !mmio_b_valid;
    assign wr_fire = mmio_wr_valid && mmio_wr_ready;

    // Write response held until the master takes it
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_b_valid <= 1'b0;
        end
        else if (wr_fire)
        begin
            mmio_b_valid <= 1'b1;
        end
        else if (mmio_b_ready)
        begin
            mmio_b_valid <= 1'b0;
        end
    end

    // Write to CSR 0 launches a run
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            start <= 1'b0;
        end
        else
        begin
            start <= wr_fire && (wr_idx == '0);
        end
    end

    // Starting index from the low data bits
    always_ff @(posedge clk)
    begin
        if (wr_fire && (wr_idx == '0))
        begin
            start_id <= mmio_wr.data[IDX_W-1:0];
        end
    end

    // ==================================================
    // Read mux
    // ==================================================

    always_comb
    begin
        for (int i = 0; i < NUM_CSRS; i = i + 1)
        begin
            csr_rd[i] = 64'd0;
        end

        csr_rd[0] = TEST_ID[63:0];
        csr_rd[1] = TEST_ID[127:64];
        // Interrupt IDs and a single engine
        csr_rd[2] = {48'd0, 8'(NUM_INTR_IDS), 8'd1};
        // Returned index mask and response count
        csr_rd[3] = {40'd0, 16'(intr_mask), 8'(intr_count)};
        csr_rd[4] = {63'd0, rsp_error};
    end

    // Indices past the CSR space read as zero
    assign rd_val = (rd_idx < ADDR_IDX_W'(NUM_CSRS)) ? csr_rd[rd_idx[CSR_IDX_W-1:0]] : 64'd0;

    // ==================================================
    // Read path
    // ==================================================

    assign mmio_ar_ready = !mmio_r_valid;
    assign ar_fire = mmio_ar_valid && mmio_ar_ready;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mmio_r_valid <= 1'b0;
        end
        else if (ar_fire)
        begin
            mmio_r_valid <= 1'b1;
        end
        else if (mmio_r_ready)
        begin
            mmio_r_valid <= 1'b0;
        end
    end

    // Register value sampled when the read is accepted
    always_ff @(posedge clk)
    begin
        if (ar_fire)
        begin
            mmio_r.data <= rd_val;
        end
    end

    // Held read data must not change under back-pressure
    assert property (@(posedge clk) disable iff (!reset_n)
        mmio_r_valid && !mmio_r_ready |=> mmio_r_valid && $stable(mmio_r));

endmodule

/* logic/intr_cmd_engine.sv */
// ==================================================
// Countdown engine issuing interrupt write commands
// ==================================================

`timescale 1ns/1ns

module intr_cmd_engine
  #(
    parameter int NUM_INTR_IDS = 4
    )
   (
    input  logic                              clk,
    input  logic                              reset_n,

    input  logic                              start,
    input  logic [$clog2(NUM_INTR_IDS)-1:0]   start_id,

    // Host write command and data
    output logic                              host_aw_valid,
    output intr_test_pkg::t_host_aw           host_aw,
    input  logic                              host_aw_ready,
    output logic                              host_w_valid,
    output intr_test_pkg::t_host_w            host_w,
    input  logic                              host_w_ready
    );

    import intr_test_pkg::*;

    localparam int IDX_W = $clog2(NUM_INTR_IDS);

    t_eng_state     state;
    logic [IDX_W-1:0] cur_idx;
    logic           beat_fire;
    t_hc_user_flags cmd_flags;

    // aw and w move as one beat
    assign beat_fire = (state == ENG_ACTIVE) && host_aw_ready && host_w_ready;

    // ==================================================
    // Countdown state
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ENG_IDLE;
            cur_idx <= '0;
        end
        else if (start)
        begin
            // A start also restarts an active run
            state <= ENG_ACTIVE;
            cur_idx <= start_id;
        end
        else if (beat_fire)
        begin
            // Index 0 is the last command
            if (cur_idx == '0)
            begin
                state <= ENG_IDLE;
            end
            cur_idx <= cur_idx - 1'b1;
        end
    end

    // ==================================================
    // Command payload
    // ==================================================

    always_comb
    begin
        cmd_flags = '0;
        cmd_flags.interrupt = 1'b1;

        // Valid held until the host takes the beat
        host_aw_valid = (state == ENG_ACTIVE);
        host_w_valid = (state == ENG_ACTIVE);

        // Interrupt vector in the low address bits
        host_aw = '0;
        host_aw.addr = HOST_ADDR_W'(cur_idx);
        host_aw.user[HC_UFLAG_WIDTH-1:0] = cmd_flags;
        // Index echoed above the flags to match responses
        host_aw.user[HC_UFLAG_WIDTH +: IDX_W] = cur_idx;

        // Empty data in one full beat
        host_w = '0;
        host_w.strb = '1;
        host_w.last = 1'b1;
    end

    // First command follows a start with the starting index
    assert property (@(posedge clk) disable iff (!reset_n)
        start |=> host_aw_valid && host_w_valid
                  && (host_aw.addr == HOST_ADDR_W'($past(start_id))));

    // Stalled beat keeps its payload unless a restart arrives
    assert property (@(posedge clk) disable iff (!reset_n)
        host_aw_valid && !(host_aw_ready && host_w_ready) && !start
        |=> host_aw_valid && $stable(host_aw) && $stable(host_w));

endmodule

/* logic/intr_rsp_tracker.sv */
// ==================================================
// Write response counter, index mask, sticky error
// ==================================================

`timescale 1ns/1ns

module intr_rsp_tracker
  #(
    parameter int NUM_INTR_IDS = 4
    )
   (
    input  logic                              clk,
    input  logic                              reset_n,

    input  logic                              start,

    // Host write response, always accepted
    input  logic                              host_b_valid,
    input  intr_test_pkg::t_host_b            host_b,

    // Status to the CSR manager
    output logic [$clog2(NUM_INTR_IDS):0]     intr_count,
    output logic [NUM_INTR_IDS-1:0]           intr_mask,
    output logic                              rsp_error
    );

    import intr_test_pkg::*;

    localparam int IDX_W = $clog2(NUM_INTR_IDS);

    t_hc_user_flags   rsp_flags;
    logic [IDX_W-1:0] rsp_idx;
    logic             rsp_intr;
    logic             rsp_bad;

    // ==================================================
    // User field decode
    // ==================================================

    // Flags in the low user bits
    assign rsp_flags = t_hc_user_flags'(host_b.user[HC_UFLAG_WIDTH-1:0]);
    // Index returned above the flags
    assign rsp_idx = host_b.user[HC_UFLAG_WIDTH +: IDX_W];

    assign rsp_intr = host_b_valid && rsp_flags.interrupt;
    // Missing interrupt or unexpected fence
    assign rsp_bad = host_b_valid && (!rsp_flags.interrupt || rsp_flags.fence);

    // ==================================================
    // Counters and error
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n || start)
        begin
            intr_count <= '0;
            intr_mask <= '0;
            rsp_error <= 1'b0;
        end
        else
        begin
            // Only interrupt responses are counted
            if (rsp_intr)
            begin
                intr_count <= intr_count + 1'b1;
                intr_mask[rsp_idx] <= 1'b1;
            end

            // Sticky until next start
            if (rsp_bad)
            begin
                rsp_error <= 1'b1;
            end
        end
    end

endmodule

/* logic/intr_test_afu.sv */
// ==================================================
// Interrupt test top: CSR manager, engine, tracker
// ==================================================

`timescale 1ns/1ns

module intr_test_afu
  #(
    parameter int NUM_INTR_IDS = 4
    )
   (
    input  logic                                  clk,
    input  logic                                  reset_n,

    // MMIO lite slave
    input  logic                                  mmio_wr_valid,
    input  intr_test_pkg::t_mmio_wr               mmio_wr,
    output logic                                  mmio_wr_ready,
    output logic                                  mmio_b_valid,
    input  logic                                  mmio_b_ready,
    input  logic                                  mmio_ar_valid,
    input  logic [intr_test_pkg::MMIO_ADDR_W-1:0] mmio_ar_addr,
    output logic                                  mmio_ar_ready,
    output logic                                  mmio_r_valid,
    output intr_test_pkg::t_mmio_rd_rsp           mmio_r,
    input  logic                                  mmio_r_ready,

    // Host write channel
    output logic                                  host_aw_valid,
    output intr_test_pkg::t_host_aw               host_aw,
    input  logic                                  host_aw_ready,
    output logic                                  host_w_valid,
    output intr_test_pkg::t_host_w                host_w,
    input  logic                                  host_w_ready,
    input  logic                                  host_b_valid,
    input  intr_test_pkg::t_host_b                host_b
    );

    // Run control
    logic                              start;
    logic [$clog2(NUM_INTR_IDS)-1:0]   start_id;

    // Tracker status
    logic [$clog2(NUM_INTR_IDS):0]     intr_count;
    logic [NUM_INTR_IDS-1:0]           intr_mask;
    logic                              rsp_error;

    csr_mgr #(.NUM_INTR_IDS(NUM_INTR_IDS)) csr_mgr_i
       (
        .clk, .reset_n,
        .mmio_wr_valid, .mmio_wr, .mmio_wr_ready, .mmio_b_valid, .mmio_b_ready,
        .mmio_ar_valid, .mmio_ar_addr, .mmio_ar_ready,
        .mmio_r_valid, .mmio_r, .mmio_r_ready,
        .intr_count, .intr_mask, .rsp_error,
        .start, .start_id
        );

    intr_cmd_engine #(.NUM_INTR_IDS(NUM_INTR_IDS)) engine_i
       (
        .clk, .reset_n,
        .start, .start_id,
        .host_aw_valid, .host_aw, .host_aw_ready,
        .host_w_valid, .host_w, .host_w_ready
        );

    intr_rsp_tracker #(.NUM_INTR_IDS(NUM_INTR_IDS)) tracker_i
       (
        .clk, .reset_n,
        .start,
        .host_b_valid, .host_b,
        .intr_count, .intr_mask, .rsp_error
        );

endmodule

/* logic/intr_test_pkg.sv */
// ==================================================
// Interrupt test package: CSR map, user flags,
// host and MMIO bus structs, engine states, test ID
// ==================================================

package intr_test_pkg;

    // Global CSR space
    localparam int NUM_CSRS = 8;
    localparam int MMIO_ADDR_W = 16;

    // Host write channel widths
    localparam int HOST_ADDR_W = 48;
    localparam int HC_UFLAG_WIDTH = 8;
    localparam int HC_USER_W = 16;

    // Test identifier returned in CSR 0 (low) and CSR 1 (high)
    localparam logic [127:0] TEST_ID = 128'h85d2a7e8_afd3_4307_bbc0_10592f1e1366;

    // Low user flags, interrupt in bit 0 and fence in bit 1
    typedef struct packed {
        logic [5:0] rsvd;
        logic       fence;
        logic       interrupt;
    } t_hc_user_flags;

    // Write command
    typedef struct packed {
        logic [HOST_ADDR_W-1:0] addr;
        logic [HC_USER_W-1:0]   user;
    } t_host_aw;

    // Write data beat
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
        logic        last;
    } t_host_w;

    // Write response
    typedef struct packed {
        logic [1:0]           resp;
        logic [HC_USER_W-1:0] user;
    } t_host_b;

    // MMIO write request, address and data travel together
    typedef struct packed {
        logic [MMIO_ADDR_W-1:0] addr;
        logic [63:0]            data;
    } t_mmio_wr;

    // MMIO read data
    typedef struct packed {
        logic [63:0] data;
    } t_mmio_rd_rsp;

    // Command engine states
    typedef enum logic {
        ENG_IDLE,
        ENG_ACTIVE
    } t_eng_state;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile the interrupt test design with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f intr_test.f --top-module intr_test_tb -Mdir obj_dir \
    && ./obj_dir/Vintr_test_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

grep -q -F '** FAIL **' sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }

/* tb/host_chan_model.sv */
// ==================================================
// Host channel model with random ready, delayed
// in-order write responses and response corruption
// ==================================================

`timescale 1ns/1ns

module host_chan_model
   (
    input  logic                    clk,
    input  logic                    reset_n,

    // Write command and data handshake from the DUT
    input  logic                    host_aw_valid,
    input  intr_test_pkg::t_host_aw host_aw,
    output logic                    host_aw_ready,
    input  logic                    host_w_valid,
    output logic                    host_w_ready,

    // Write response back to the DUT
    output logic                    host_b_valid,
    output intr_test_pkg::t_host_b  host_b,

    // Corruption request from the testbench top
    input  logic                    corrupt_arm,
    input  logic [1:0]              corrupt_kind,

    output int                      proto_errors
    );

    import intr_test_pkg::*;

    integer               seed;
    logic [HC_USER_W-1:0] rsp_q [$];
    int                   gap;
    logic                 armed;
    logic [1:0]           armed_kind;
    logic [31:0]          rnd;
    logic [HC_USER_W-1:0] user;
    t_hc_user_flags       flags;

    initial
    begin
        seed = 32'h9bf298a1;
        host_aw_ready = 1'b0;
        host_w_ready = 1'b0;
        host_b_valid = 1'b0;
        host_b = '0;
        proto_errors = 0;
        gap = 0;
        armed = 1'b0;
        armed_kind = 2'd0;
    end

    // ==================================================
    // Sample at the edge and drive 1 ns later
    // ==================================================

    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_q.delete();
            gap = 0;
            armed = 1'b0;
        end
        else
        begin
            // Command and data sides must rise and fall together
            assert (host_aw_valid == host_w_valid)
            else
            begin
                proto_errors++;
                $display("Write command valid and write data valid did not move together");
            end

            // Accepted beat keeps its user field for the response
            if (host_aw_valid && host_w_valid && host_aw_ready && host_w_ready)
            begin
                rsp_q.push_back(host_aw.user);
            end

            // One corrupted response per request
            if (corrupt_arm)
            begin
                armed = 1'b1;
                armed_kind = corrupt_kind;
            end
        end

        #1;
        rnd = $random(seed);

        // Each ready high three cycles in four
        host_aw_ready = rnd[0] | rnd[1];
        host_w_ready = rnd[2] | rnd[3];

        // A response beat lasts one cycle since bready is always high
        host_b_valid = 1'b0;
        host_b = '0;
        if (gap > 0)
        begin
            gap--;
        end
        else if (rsp_q.size() > 0)
        begin
            user = rsp_q.pop_front();
            if (armed)
            begin
                flags = t_hc_user_flags'(user[HC_UFLAG_WIDTH-1:0]);
                // Kind 1 drops the interrupt flag and any other kind raises fence
                if (armed_kind == 2'd1)
                begin
                    flags.interrupt = 1'b0;
                end
                else
                begin
                    flags.fence = 1'b1;
                end
                user[HC_UFLAG_WIDTH-1:0] = flags;
                armed = 1'b0;
            end
            host_b_valid = 1'b1;
            host_b.user = user;
            // Gap of 0 to 3 cycles before the next response
            gap = int'(rnd[5:4]);
        end
    end

endmodule

/* tb/intr_test_tb.sv */
// ==================================================
// Interrupt test testbench with MMIO driver, host model,
// expected results, checks and timeout
// ==================================================

`timescale 1ns/1ns

module intr_test_tb;

    import intr_test_pkg::*;

    localparam int NUM_INTR_IDS = 4;
    localparam int NUM_RUNS = 12;
    localparam int CYCLES_PER_RUN = 1000;
    // Random and fixed runs with margin
    localparam int TIMEOUT_CYCLES = (NUM_RUNS + 8) * CYCLES_PER_RUN;
    localparam int POLL_LIMIT = 100;

    localparam logic [1:0] CORRUPT_NONE = 2'd0;
    localparam logic [1:0] CORRUPT_CLEAR_INTR = 2'd1;
    localparam logic [1:0] CORRUPT_SET_FENCE = 2'd2;

    logic                   clk;
    logic                   reset_n;
    logic                   mmio_wr_valid;
    t_mmio_wr               mmio_wr;
    logic                   mmio_wr_ready;
    logic                   mmio_b_valid;
    logic                   mmio_b_ready;
    logic                   mmio_ar_valid;
    logic [MMIO_ADDR_W-1:0] mmio_ar_addr;
    logic                   mmio_ar_ready;
    logic                   mmio_r_valid;
    t_mmio_rd_rsp           mmio_r;
    logic                   mmio_r_ready;
    logic                   host_aw_valid;
    t_host_aw               host_aw;
    logic                   host_aw_ready;
    logic                   host_w_valid;
    t_host_w                host_w;
    logic                   host_w_ready;
    logic                   host_b_valid;
    t_host_b                host_b;
    logic                   corrupt_arm;
    logic [1:0]             corrupt_kind;
    int                     proto_errors;

    integer                 seed;
    int                     error_count;
    int                     cycle_count;
    t_host_aw               seen_q [$];
    logic [63:0]            rd;

    intr_test_afu #(.NUM_INTR_IDS(NUM_INTR_IDS)) uut
       (
        .clk, .reset_n,
        .mmio_wr_valid, .mmio_wr, .mmio_wr_ready, .mmio_b_valid, .mmio_b_ready,
        .mmio_ar_valid, .mmio_ar_addr, .mmio_ar_ready,
        .mmio_r_valid, .mmio_r, .mmio_r_ready,
        .host_aw_valid, .host_aw, .host_aw_ready,
        .host_w_valid, .host_w, .host_w_ready,
        .host_b_valid, .host_b
        );

    host_chan_model host_i
       (
        .clk, .reset_n,
        .host_aw_valid, .host_aw, .host_aw_ready,
        .host_w_valid, .host_w_ready,
        .host_b_valid, .host_b,
        .corrupt_arm, .corrupt_kind, .proto_errors
        );

    always #5 clk = ~clk;

    // ==================================================
    // Checks, monitor and timeout
    // ==================================================

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            error_count++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    // Record every transferred command beat
    always @(posedge clk)
    begin
        if (reset_n && host_aw_valid && host_aw_ready && host_w_valid && host_w_ready)
        begin
            seen_q.push_back(host_aw);
            check_value("host_w.data", host_w.data, 64'd0);
            check_value("host_w.strb", 64'(host_w.strb), 64'hff);
            check_value("host_w.last", 64'(host_w.last), 64'd1);
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ==================================================
    // MMIO driver with random b and r back-pressure
    // ==================================================

    function automatic logic [MMIO_ADDR_W-1:0] csr_addr(input int idx);
        return MMIO_ADDR_W'(idx * 8);
    endfunction

    task automatic mmio_write(input logic [MMIO_ADDR_W-1:0] addr, input logic [63:0] data);
        int hold;
        mmio_wr_valid = 1'b1;
        mmio_wr.addr = addr;
        mmio_wr.data = data;
        @(posedge clk);
        while (!mmio_wr_ready)
        begin
            @(posedge clk);
        end
        #1;
        mmio_wr_valid = 1'b0;
        hold = $unsigned($random(seed)) % 4;
        assert (mmio_b_valid)
        else
        begin
            error_count++;
            $display("No write response after an accepted write");
        end
        // Held response blocks the next write
        repeat (hold)
        begin
            @(posedge clk);
            assert (mmio_b_valid && !mmio_wr_ready)
            else
            begin
                error_count++;
                $display("Held write response dropped or next write not blocked");
            end
            #1;
        end
        mmio_b_ready = 1'b1;
        @(posedge clk);
        #1;
        mmio_b_ready = 1'b0;
    endtask

    task automatic mmio_read(input logic [MMIO_ADDR_W-1:0] addr, output logic [63:0] data);
        int          hold;
        logic [63:0] held;
        mmio_ar_valid = 1'b1;
        mmio_ar_addr = addr;
        @(posedge clk);
        while (!mmio_ar_ready)
        begin
            @(posedge clk);
        end
        #1;
        mmio_ar_valid = 1'b0;
        hold = $unsigned($random(seed)) % 4;
        held = mmio_r.data;
        assert (mmio_r_valid)
        else
        begin
            error_count++;
            $display("No read data after an accepted read");
        end
        // Data must stay put and the next read must wait
        repeat (hold)
        begin
            @(posedge clk);
            assert (mmio_r_valid && !mmio_ar_ready)
            else
            begin
                error_count++;
                $display("Held read data dropped or next read not blocked");
            end
            check_value("mmio_r.data held", mmio_r.data, held);
            #1;
        end
        mmio_r_ready = 1'b1;
        @(posedge clk);
        data = mmio_r.data;
        #1;
        mmio_r_ready = 1'b0;
    endtask

    // ==================================================
    // Run model with indices S down to 0, count S+1 and mask 0..S
    // ==================================================

    function automatic int pick_start_index(input int lowest);
        return lowest + ($unsigned($random(seed)) % (NUM_INTR_IDS - lowest));
    endfunction

    task automatic run_countdown(input int s, input logic [1:0] kind);
        int          polls;
        int          exp_count;
        int          exp_idx;
        logic        done;
        logic [15:0] exp_mask;
        logic [63:0] val;
        seen_q.delete();
        if (kind != CORRUPT_NONE)
        begin
            corrupt_kind = kind;
            corrupt_arm = 1'b1;
            @(posedge clk);
            #1;
            corrupt_arm = 1'b0;
        end
        mmio_write(csr_addr(0), 64'(s));

        exp_count = s + 1;
        exp_mask = 16'((32'd1 << (s + 1)) - 1);
        // First response carries index S and loses its interrupt flag
        if (kind == CORRUPT_CLEAR_INTR)
        begin
            exp_count--;
            exp_mask[s] = 1'b0;
        end

        polls = 0;
        done = 1'b0;
        while (!done && polls < POLL_LIMIT)
        begin
            mmio_read(csr_addr(3), val);
            polls++;
            done = (val[7:0] == 8'(exp_count));
        end
        assert (done)
        else
        begin
            error_count++;
            $display("Run from index %0d never reached its response count", s);
        end

        // Late responses would show up here
        repeat (8)
        begin
            @(posedge clk);
        end
        #1;
        mmio_read(csr_addr(3), val);
        check_value("csr3 intr_count", 64'(val[7:0]), 64'(exp_count));
        check_value("csr3 intr_mask", 64'(val[23:8]), 64'(exp_mask));
        mmio_read(csr_addr(4), val);
        check_value("csr4 rsp_error", val, 64'(kind != CORRUPT_NONE));

        // Command order S down to 0 with address equal to index
        check_value("command total", 64'(seen_q.size()), 64'(s + 1));
        foreach (seen_q[i])
        begin
            exp_idx = s - i;
            check_value("host_aw.addr", 64'(seen_q[i].addr), 64'(exp_idx));
            check_value("host_aw.user", 64'(seen_q[i].user),
                        64'((exp_idx << HC_UFLAG_WIDTH) | 1));
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_wr = '0;
        mmio_b_ready = 1'b0;
        mmio_ar_valid = 1'b0;
        mmio_ar_addr = '0;
        mmio_r_ready = 1'b0;
        corrupt_arm = 1'b0;
        corrupt_kind = CORRUPT_NONE;
        seed = 32'h9bf298a1;
        error_count = 0;
        cycle_count = 0;

        repeat (2)
        begin
            @(posedge clk);
        end
        #1;
        reset_n = 1'b1;

        // Test ID, configuration and unused CSRs
        mmio_read(csr_addr(0), rd);
        check_value("csr0 test_id_lo", rd, TEST_ID[63:0]);
        mmio_read(csr_addr(1), rd);
        check_value("csr1 test_id_hi", rd, TEST_ID[127:64]);
        mmio_read(csr_addr(2), rd);
        check_value("csr2 config", rd, 64'((NUM_INTR_IDS << 8) | 1));
        for (int i = 5; i < NUM_CSRS; i++)
        begin
            mmio_read(csr_addr(i), rd);
            check_value("csr unused", rd, 64'd0);
        end

        // Write to another CSR issues no command
        mmio_write(csr_addr(5), 64'd3);
        repeat (10)
        begin
            @(posedge clk);
        end
        #1;
        assert (seen_q.size() == 0)
        else
        begin
            error_count++;
            $display("Commands issued after a write to a CSR other than 0");
        end

        // Full run followed by a short one that shows only the new values
        run_countdown(NUM_INTR_IDS - 1, CORRUPT_NONE);
        run_countdown(0, CORRUPT_NONE);

        for (int r = 0; r < NUM_RUNS; r++)
        begin
            run_countdown(pick_start_index(0), CORRUPT_NONE);
        end

        // Each error run is followed by a clean one that clears it
        run_countdown(pick_start_index(1), CORRUPT_CLEAR_INTR);
        run_countdown(pick_start_index(0), CORRUPT_NONE);
        run_countdown(pick_start_index(0), CORRUPT_SET_FENCE);
        run_countdown(pick_start_index(0), CORRUPT_NONE);

        $display("Test done: %0d check errors, %0d host protocol errors",
                 error_count, proto_errors);
        if (error_count == 0 && proto_errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
